/* build.f */
+incdir+.
mem_pkg.sv
mem_arbiter.sv
mem_cfg_regs.sv
sram_model.sv
mem_subsys_top.sv
tb_mem_subsys.sv

/* mem_arbiter.sv */
/*
 * Instruction/data arbiter for the shared memory port.
 * Seven-state FSM, data first from idle, queued second request,
 * abort of a fetch withdrawn before issue.
 * Runtime byte swap of write data, byte enables and read data.
 */
`timescale 1ns/1ps

module mem_arbiter (
  input  logic                  CLK,
  input  logic                  nRST,
  input  mem_pkg::gen_bus_req_t i_ibus_req,
  output mem_pkg::gen_bus_rsp_t o_ibus_rsp,
  input  mem_pkg::gen_bus_req_t i_dbus_req,
  output mem_pkg::gen_bus_rsp_t o_dbus_rsp,
  output mem_pkg::gen_bus_req_t o_mem_req,
  input  mem_pkg::gen_bus_rsp_t i_mem_rsp,
  input  mem_pkg::mem_cfg_t     i_cfg,
  output mem_pkg::arb_evt_t     o_evt
);
  import mem_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    INSTR_REQ,       // fetch issue cycle.
    INSTR_DATA_REQ,  // fetch at memory, data queued.
    INSTR_WAIT,      // fetch at memory.
    DATA_REQ,        // data issue cycle.
    DATA_INSTR_REQ,  // data at memory, fetch queued.
    DATA_WAIT        // data at memory.
  } state_t;

  state_t       state;
  state_t       next_state;
  logic         d_pend;    // data port asking.
  logic         i_pend;    // fetch port asking.
  logic         mem_done;  // memory completes this cycle.
  logic         i_busy;
  logic         d_busy;
  gen_bus_req_t sel_req;   // owner's request before swap.
  word_t        rdata;

  // byte order reversal, shared by both directions.
  function automatic word_t swap_word(input word_t w);
    swap_word = {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  // lanes follow their bytes.
  function automatic byte_en_t swap_be(input byte_en_t b);
    swap_be = {b[0], b[1], b[2], b[3]};
  endfunction

  assign d_pend   = i_dbus_req.ren || i_dbus_req.wen;
  assign i_pend   = i_ibus_req.ren;
  assign mem_done = !i_mem_rsp.busy;

  // ==============================
  // state machine
  // ==============================
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (d_pend) next_state = DATA_REQ;          // data wins a tie.
        else if (i_pend) next_state = INSTR_REQ;
      end
      INSTR_REQ: begin
        if (!i_pend) next_state = IDLE;             // fetch withdrawn, abort.
        else if (d_pend) next_state = INSTR_DATA_REQ;
        else next_state = INSTR_WAIT;
      end
      INSTR_WAIT: begin
        if (mem_done) next_state = d_pend ? DATA_REQ : IDLE;
        else if (d_pend) next_state = INSTR_DATA_REQ;
      end
      INSTR_DATA_REQ: begin
        if (mem_done) next_state = DATA_WAIT;       // queued data goes straight out.
      end
      DATA_REQ: begin
        if (i_pend) next_state = DATA_INSTR_REQ;
        else next_state = DATA_WAIT;
      end
      DATA_WAIT: begin
        if (mem_done) next_state = i_pend ? INSTR_REQ : IDLE;
        else if (i_pend) next_state = DATA_INSTR_REQ;
      end
      DATA_INSTR_REQ: begin
        if (mem_done) next_state = i_pend ? INSTR_WAIT : IDLE;
        else if (!i_pend) next_state = DATA_WAIT;   // queued fetch dropped.
      end
      default: next_state = IDLE;
    endcase
  end

  // ==============================
  // request mux and busy routing
  // ==============================
  always_comb begin
    sel_req = '0;   // nothing at memory in idle and issue cycles.
    i_busy  = 1'b1;
    d_busy  = 1'b1;
    case (state)
      INSTR_WAIT, INSTR_DATA_REQ: begin
        sel_req     = i_ibus_req;
        sel_req.wen = 1'b0;         // fetch port only reads.
        i_busy      = i_mem_rsp.busy;
      end
      DATA_WAIT, DATA_INSTR_REQ: begin
        sel_req = i_dbus_req;
        d_busy  = i_mem_rsp.busy;
      end
      default: begin
        sel_req = '0;
      end
    endcase
  end

  // little endian bus, memory kept big endian.
  always_comb begin
    o_mem_req = sel_req;
    if (i_cfg.little_endian) begin
      o_mem_req.wdata   = swap_word(sel_req.wdata);
      o_mem_req.byte_en = swap_be(sel_req.byte_en);
    end
  end

  assign rdata = i_cfg.little_endian ? swap_word(i_mem_rsp.rdata) : i_mem_rsp.rdata;

  assign o_ibus_rsp = '{busy: i_busy, rdata: rdata};
  assign o_dbus_rsp = '{busy: d_busy, rdata: rdata};
  assign o_evt      = '{instr_done: !i_busy, data_done: !d_busy};  // completing cycle.

  // ==============================
  // checks
  // ==============================
  a_mem_one_op: assert property (@(posedge CLK) disable iff (!nRST)
    !(o_mem_req.ren && o_mem_req.wen))
    else $error("memory sees read and write together");

  a_one_done: assert property (@(posedge CLK) disable iff (!nRST)
    i_busy || d_busy)
    else $error("both ports complete in one cycle");

endmodule

/* mem_cfg_regs.sv */
/*
 * AXI4-Lite configuration registers.
 * CTRL (byte order), WAIT (memory wait states),
 * ICOUNT/DCOUNT completed access counters.
 * Single outstanding response per direction.
 */
`timescale 1ns/1ps

module mem_cfg_regs (
  input  logic               CLK,
  input  logic               nRST,
  input  mem_pkg::axil_m2s_t i_axil,
  output mem_pkg::axil_s2m_t o_axil,
  input  mem_pkg::arb_evt_t  i_evt,
  output mem_pkg::mem_cfg_t  o_cfg
);
  import mem_pkg::*;

  logic   wr_take;        // write accepted this cycle.
  logic   rd_take;        // read accepted this cycle.
  logic   bvalid;
  logic   rvalid;
  word_t  rdata;          // held read payload.
  word_t  rd_mux;
  logic   little_endian;
  wait_t  wait_states;
  count_t icount;
  count_t dcount;

  // both channels together, nothing pending.
  assign wr_take = i_axil.awvalid && i_axil.wvalid && !bvalid;
  assign rd_take = i_axil.arvalid && !rvalid;

  // ==============================
  // write channel
  // ==============================
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      bvalid <= 1'b0;
    end else if (wr_take) begin
      bvalid <= 1'b1;
    end else if (i_axil.bready) begin
      bvalid <= 1'b0;    // response taken.
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      little_endian <= 1'b0;        // big endian out of reset.
      wait_states   <= WAIT_RESET;
    end else if (wr_take && i_axil.wstrb[0]) begin
      case (i_axil.awaddr)
        REG_CTRL: little_endian <= i_axil.wdata[0];
        REG_WAIT: wait_states   <= i_axil.wdata[3:0];
        default:  ;                 // counters and holes are read only.
      endcase
    end
  end

  // ==============================
  // access counters
  // ==============================
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      icount <= '0;
      dcount <= '0;
    end else begin
      if (i_evt.instr_done) begin
        icount <= icount + count_t'(1);
      end
      if (i_evt.data_done) begin
        dcount <= dcount + count_t'(1);
      end
    end
  end

  // ==============================
  // read channel
  // ==============================
  always_comb begin
    case (i_axil.araddr)
      REG_CTRL:   rd_mux = word_t'(little_endian);
      REG_WAIT:   rd_mux = word_t'(wait_states);
      REG_ICOUNT: rd_mux = icount;
      REG_DCOUNT: rd_mux = dcount;
      default:    rd_mux = '0;      // unmapped.
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      rvalid <= 1'b0;
    end else if (rd_take) begin
      rvalid <= 1'b1;
    end else if (i_axil.rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (rd_take) begin
      rdata <= rd_mux;   // sampled at accept.
    end
  end

  assign o_axil = '{awready: wr_take, wready: wr_take, bvalid: bvalid, bresp: RESP_OKAY,
                    arready: rd_take, rvalid: rvalid, rdata: rdata, rresp: RESP_OKAY};

  assign o_cfg = '{little_endian: little_endian, wait_states: wait_states};

  // ==============================
  // checks
  // ==============================
  a_b_hold: assert property (@(posedge CLK) disable iff (!nRST)
    bvalid && !i_axil.bready |=> bvalid)
    else $error("bvalid dropped before bready");

  a_r_hold: assert property (@(posedge CLK) disable iff (!nRST)
    rvalid && !i_axil.rready |=> rvalid && $stable(rdata))
    else $error("read response changed before rready");

endmodule

/* mem_pkg.sv */
/*
 * Shared types for the memory subsystem.
 * Word, address, byte-enable, wait and counter types.
 * Generic bus, AXI4-Lite, configuration and event structs.
 * Memory depth, register map and reset values.
 */
package mem_pkg;

  // ==============================
  // widths
  // ==============================
  typedef logic [31:0] word_t;       // data word.
  typedef logic [31:0] addr_t;       // byte address.
  typedef logic [3:0]  byte_en_t;    // one bit per byte lane.
  typedef logic [3:0]  wait_t;       // memory wait states.
  typedef logic [31:0] count_t;      // access counter.
  typedef logic [3:0]  reg_addr_t;   // register offset.
  typedef logic [1:0]  axil_resp_t;  // axi response code.

  localparam int MEM_WORDS = 1024;                  // memory depth in words.
  localparam int MEM_IDX_W = $clog2(MEM_WORDS);     // word index width.

  localparam reg_addr_t  REG_CTRL   = 4'h0;  // bit 0 little endian.
  localparam reg_addr_t  REG_WAIT   = 4'h4;  // wait states, low nibble.
  localparam reg_addr_t  REG_ICOUNT = 4'h8;  // fetches done.
  localparam reg_addr_t  REG_DCOUNT = 4'hC;  // loads/stores done.
  localparam wait_t      WAIT_RESET = 4'd1;
  localparam axil_resp_t RESP_OKAY  = 2'b00;

  // ==============================
  // bundles
  // ==============================
  typedef struct packed {
    logic     ren;
    logic     wen;
    addr_t    addr;
    word_t    wdata;
    byte_en_t byte_en;
  } gen_bus_req_t;  // requester toward memory.

  typedef struct packed {
    logic  busy;   // low for the completing cycle.
    word_t rdata;
  } gen_bus_rsp_t;

  typedef struct packed {
    logic  little_endian;
    wait_t wait_states;
  } mem_cfg_t;

  typedef struct packed {
    logic instr_done;
    logic data_done;
  } arb_evt_t;  // one-cycle pulses.

  typedef struct packed {
    logic      awvalid;
    reg_addr_t awaddr;
    logic      wvalid;
    word_t     wdata;
    byte_en_t  wstrb;
    logic      bready;
    logic      arvalid;
    reg_addr_t araddr;
    logic      rready;
  } axil_m2s_t;

  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    axil_resp_t bresp;
    logic       arready;
    logic       rvalid;
    word_t      rdata;
    axil_resp_t rresp;
  } axil_s2m_t;

endpackage

/* mem_subsys_top.sv */
/*
 * Memory subsystem top level.
 * Arbiter, configuration registers and memory model.
 */
`timescale 1ns/1ps

module mem_subsys_top (
  input  logic                  CLK,
  input  logic                  nRST,
  input  mem_pkg::gen_bus_req_t i_ibus_req,
  output mem_pkg::gen_bus_rsp_t o_ibus_rsp,
  input  mem_pkg::gen_bus_req_t i_dbus_req,
  output mem_pkg::gen_bus_rsp_t o_dbus_rsp,
  input  mem_pkg::axil_m2s_t    i_axil,
  output mem_pkg::axil_s2m_t    o_axil
);
  import mem_pkg::*;

  gen_bus_req_t mem_req;  // arbiter to memory.
  gen_bus_rsp_t mem_rsp;
  mem_cfg_t     cfg;      // from register block.
  arb_evt_t     evt;      // completion pulses.

  mem_arbiter arb_i (
    .CLK        (CLK),
    .nRST       (nRST),
    .i_ibus_req (i_ibus_req),
    .o_ibus_rsp (o_ibus_rsp),
    .i_dbus_req (i_dbus_req),
    .o_dbus_rsp (o_dbus_rsp),
    .o_mem_req  (mem_req),
    .i_mem_rsp  (mem_rsp),
    .i_cfg      (cfg),
    .o_evt      (evt)
  );

  mem_cfg_regs regs_i (
    .CLK    (CLK),
    .nRST   (nRST),
    .i_axil (i_axil),
    .o_axil (o_axil),
    .i_evt  (evt),
    .o_cfg  (cfg)
  );

  sram_model sram_i (
    .CLK           (CLK),
    .nRST          (nRST),
    .i_req         (mem_req),
    .o_rsp         (mem_rsp),
    .i_wait_states (cfg.wait_states)
  );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_mem_subsys \
  -Mdir obj_dir -o sim_mem_subsys

out=$(./obj_dir/sim_mem_subsys)
echo "$out"

if grep -qx "PASS: all tests" <<< "$out"; then
  exit 0
else
  exit 1
fi

/* sram_model.sv */
/*
 * Behavioral single-port word memory.
 * Byte-enabled writes, programmable wait states,
 * generic bus busy timing.
 */
`timescale 1ns/1ps

module sram_model (
  input  logic                  CLK,
  input  logic                  nRST,
  input  mem_pkg::gen_bus_req_t i_req,
  output mem_pkg::gen_bus_rsp_t o_rsp,
  input  mem_pkg::wait_t        i_wait_states
);
  import mem_pkg::*;

  word_t                mem [MEM_WORDS];
  logic                 active;   // access in progress.
  wait_t                cnt;      // cycles left before completion.
  logic                 done;
  logic                 req;
  logic [MEM_IDX_W-1:0] idx;

  assign req  = i_req.ren || i_req.wen;
  assign idx  = i_req.addr[MEM_IDX_W+1:2];   // wraps on depth.
  assign done = active && (cnt == '0);

  // ==============================
  // wait-state countdown
  // ==============================
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      active <= 1'b0;
      cnt    <= '0;
    end else if (!active) begin
      if (req) begin
        active <= 1'b1;             // first seen, start counting.
        cnt    <= i_wait_states;
      end
    end else if (done) begin
      active <= 1'b0;               // next request is seen as new.
    end else begin
      cnt <= cnt - wait_t'(1);
    end
  end

  // write lands in the completing cycle.
  always_ff @(posedge CLK) begin
    if (done && i_req.wen) begin
      for (int b = 0; b < $bits(byte_en_t); b++) begin
        if (i_req.byte_en[b]) begin
          mem[idx][8*b +: 8] <= i_req.wdata[8*b +: 8];
        end
      end
    end
  end

  assign o_rsp = '{busy: !done, rdata: mem[idx]};  // rdata valid when busy low.

  // ==============================
  // checks
  // ==============================
  a_no_rw: assert property (@(posedge CLK) disable iff (!nRST)
    !(i_req.ren && i_req.wen))
    else $error("read and write requested together");

endmodule

/* tb_mem_tasks.svh */
/*
 * Testbench helper tasks, included in the testbench module.
 * Typed compare tasks and plain failure reporting.
 * AXI4-Lite register write/read and generic bus drivers.
 */
`ifndef TB_MEM_TASKS_SVH
`define TB_MEM_TASKS_SVH

  // ==============================
  // compare tasks
  // ==============================
  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      err_value++;
      $display("** Error: %s got 0x%08h expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input count_t got, input count_t exp);
    if (got !== exp) begin
      err_value++;
      $display("** Error: %s got 0x%08h expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic check_cfg(input string name, input mem_cfg_t got, input mem_cfg_t exp);
    if (got !== exp) begin
      err_value++;
      $display("** Error: %s got le=0x%0h wait=0x%0h expected le=0x%0h wait=0x%0h",
               name, got.little_endian, got.wait_states, exp.little_endian, exp.wait_states);
    end
  endtask

  task automatic check_resp(input string name, input axil_resp_t got, input axil_resp_t exp);
    if (got !== exp) begin
      err_value++;
      $display("** Error: %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic note_failure(input string msg);
    err_other++;
    $display("%s", msg);
  endtask

  // ==============================
  // bus drivers
  // ==============================
  task automatic axil_write(input reg_addr_t addr, input word_t data);
    @(posedge CLK);
    axil_m2s.awvalid <= 1'b1;
    axil_m2s.awaddr  <= addr;
    axil_m2s.wvalid  <= 1'b1;
    axil_m2s.wdata   <= data;
    axil_m2s.wstrb   <= 4'hF;
    do @(negedge CLK); while (!(axil_s2m.awready && axil_s2m.wready));
    @(posedge CLK);
    axil_m2s.awvalid <= 1'b0;
    axil_m2s.wvalid  <= 1'b0;
    axil_m2s.bready  <= 1'b1;    // ready from the cycle bvalid rises.
    do @(negedge CLK); while (!axil_s2m.bvalid);
    check_resp("o_axil.bresp", axil_s2m.bresp, 2'b00);   // okay.
    @(posedge CLK);
    axil_m2s.bready  <= 1'b0;
  endtask

  task automatic axil_read(input reg_addr_t addr, output word_t data);
    @(posedge CLK);
    axil_m2s.arvalid <= 1'b1;
    axil_m2s.araddr  <= addr;
    do @(negedge CLK); while (!axil_s2m.arready);
    @(posedge CLK);
    axil_m2s.arvalid <= 1'b0;
    axil_m2s.rready  <= 1'b1;
    do @(negedge CLK); while (!axil_s2m.rvalid);
    data = axil_s2m.rdata;       // held while rvalid.
    check_resp("o_axil.rresp", axil_s2m.rresp, 2'b00);   // okay.
    @(posedge CLK);
    axil_m2s.rready  <= 1'b0;
  endtask

  // one load or store held until busy drops.
  task automatic data_access(input logic we, input addr_t addr, input word_t wdata,
                             input byte_en_t be, output word_t rdata);
    @(posedge CLK);
    dbus_req <= '{ren: !we, wen: we, addr: addr, wdata: wdata, byte_en: be};
    do @(negedge CLK); while (dbus_rsp.busy);
    rdata = dbus_rsp.rdata;
    d_done_cnt++;
    @(posedge CLK);
    dbus_req <= '0;
  endtask

  task automatic instr_read(input addr_t addr, output word_t rdata);
    @(posedge CLK);
    ibus_req <= '{ren: 1'b1, wen: 1'b0, addr: addr, wdata: '0, byte_en: 4'hF};
    do @(negedge CLK); while (ibus_rsp.busy);
    rdata = ibus_rsp.rdata;
    i_done_cnt++;
    @(posedge CLK);
    ibus_req <= '0;
  endtask

`endif

/* tb_mem_subsys.sv */
/*
 * Testbench for the memory subsystem.
 * Clock, reset, reference memory model with byte order,
 * compare process, directed and random stimulus, timeout.
 */
`timescale 1ns/1ps

module tb_mem_subsys;
  import mem_pkg::*;

  localparam int N_RAND   = 24;   // write/read pairs per wait setting.
  localparam int N_FETCH  = 16;
  localparam int N_PAIR   = 8;
  localparam int N_LE     = 6;
  localparam int N_REG    = 40;   // upper bound on axi accesses.
  localparam int MAX_WAIT = 15;
  localparam int N_ACCESS = 3 * 2 * N_RAND + N_FETCH + 2 * N_PAIR + 3 * N_LE + 2 + N_REG;
  localparam int LIMIT    = N_ACCESS * (MAX_WAIT + 4) + 200;

  logic         CLK;
  logic         nRST;
  gen_bus_req_t ibus_req;
  gen_bus_rsp_t ibus_rsp;
  gen_bus_req_t dbus_req;
  gen_bus_rsp_t dbus_rsp;
  axil_m2s_t    axil_m2s;
  axil_s2m_t    axil_s2m;

  word_t  ref_mem [int];   // word index to memory-side word.
  addr_t  written_q [$];
  logic   cur_le;
  wait_t  cur_wait;
  integer seed;
  int     err_value = 0;
  int     err_other = 0;
  int     cycles = 0;
  int     i_done_cnt = 0;  // accesses driven per port.
  int     d_done_cnt = 0;
  int     done_seq = 0;
  int     i_seq = 0;
  int     d_seq = 0;

  `include "tb_mem_tasks.svh"

  mem_subsys_top dut_i (
    .CLK        (CLK),
    .nRST       (nRST),
    .i_ibus_req (ibus_req),
    .o_ibus_rsp (ibus_rsp),
    .i_dbus_req (dbus_req),
    .o_dbus_rsp (dbus_rsp),
    .i_axil     (axil_m2s),
    .o_axil     (axil_s2m)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  // ==============================
  // reference model
  // ==============================
  function automatic int word_index(input addr_t addr);
    return int'(addr[11:2]);   // wraps on memory depth.
  endfunction

  // bus lane b sits in memory lane 3-b in little-endian mode.
  function automatic void store_word(input addr_t addr, input word_t wdata, input byte_en_t be);
    word_t stored;
    stored = ref_mem.exists(word_index(addr)) ? ref_mem[word_index(addr)] : '0;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) stored[8 * (cur_le ? 3 - b : b) +: 8] = wdata[8 * b +: 8];
    end
    ref_mem[word_index(addr)] = stored;
  endfunction

  function automatic word_t expected_read(input addr_t addr);
    word_t stored;
    word_t bus;
    stored = ref_mem[word_index(addr)];
    for (int b = 0; b < 4; b++) begin
      bus[8 * b +: 8] = stored[8 * (cur_le ? 3 - b : b) +: 8];
    end
    return bus;
  endfunction

  task automatic set_wait(input wait_t w);
    axil_write(REG_WAIT, word_t'(w));
    cur_wait = w;
  endtask

  task automatic set_endian(input logic le);
    axil_write(REG_CTRL, word_t'(le));
    cur_le = le;
  endtask

  // ==============================
  // compare process
  // ==============================
  always @(negedge CLK) begin
    if (nRST && !dbus_rsp.busy) begin
      if (dbus_req.wen) store_word(dbus_req.addr, dbus_req.wdata, dbus_req.byte_en);
      else if (!dbus_req.ren) note_failure("data port completed with no request pending");
      else if (!ref_mem.exists(word_index(dbus_req.addr)))
        note_failure("data read of an address that was never written");
      else check_word("o_dbus_rsp.rdata", dbus_rsp.rdata, expected_read(dbus_req.addr));
      done_seq++;
      d_seq = done_seq;
    end
    if (nRST && !ibus_rsp.busy) begin
      if (!ibus_req.ren) note_failure("instruction port completed with no request pending");
      else if (!ref_mem.exists(word_index(ibus_req.addr)))
        note_failure("instruction read of an address that was never written");
      else check_word("o_ibus_rsp.rdata", ibus_rsp.rdata, expected_read(ibus_req.addr));
      done_seq++;
      i_seq = done_seq;
    end
  end

  always @(posedge CLK) begin
    cycles = cycles + 1;
    if (cycles >= LIMIT) begin
      $display("timeout after %0d cycles, a handshake never completed", cycles);
      $display("errors: %0d value, %0d other", err_value, err_other);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // ==============================
  // stimulus
  // ==============================
  initial begin
    word_t    rd;
    word_t    rd_i;
    word_t    wd;
    addr_t    a;
    addr_t    a2;
    byte_en_t be;
    mem_cfg_t exp_cfg;
    addr_t    le_addr [N_LE];
    word_t    le_data [N_LE];
    seed     = 32'h920;
    nRST     <= 1'b0;
    ibus_req <= '0;
    dbus_req <= '0;
    axil_m2s <= '0;
    cur_le   = 1'b0;
    cur_wait = WAIT_RESET;
    repeat (4) @(posedge CLK);
    nRST <= 1'b1;

    // reset values, readback, read-only counters.
    axil_read(REG_CTRL, rd);
    check_word("o_axil.rdata CTRL", rd, 32'h0);
    axil_read(REG_WAIT, rd);
    check_word("o_axil.rdata WAIT", rd, word_t'(WAIT_RESET));
    axil_read(REG_ICOUNT, rd);
    check_count("o_axil.rdata ICOUNT", rd, '0);
    axil_read(REG_DCOUNT, rd);
    check_count("o_axil.rdata DCOUNT", rd, '0);
    axil_read(4'h2, rd);
    check_word("o_axil.rdata unmapped", rd, 32'h0);
    set_endian(1'b1);
    axil_read(REG_CTRL, rd);
    check_word("o_axil.rdata CTRL", rd, 32'h1);
    set_wait(4'd9);
    axil_read(REG_WAIT, rd);
    check_word("o_axil.rdata WAIT", rd, 32'h9);
    exp_cfg = '{little_endian: cur_le, wait_states: cur_wait};
    @(negedge CLK);
    check_cfg("cfg", dut_i.cfg, exp_cfg);
    axil_write(REG_ICOUNT, 32'h55);
    axil_write(REG_DCOUNT, 32'hAA);
    axil_read(REG_ICOUNT, rd);
    check_count("o_axil.rdata ICOUNT", rd, '0);
    axil_read(REG_DCOUNT, rd);
    check_count("o_axil.rdata DCOUNT", rd, '0);
    set_endian(1'b0);

    // random stores and loads on 16 words with random upper bits.
    for (int k = 0; k < 3; k++) begin
      set_wait(wait_t'(3 * k));
      for (int n = 0; n < N_RAND; n++) begin
        a  = addr_t'($random(seed)) & 32'hFFFF_F03C;
        wd = $random(seed);
        be = ref_mem.exists(word_index(a)) ? byte_en_t'($random(seed)) : 4'hF;
        data_access(1'b1, a, wd, be, rd);
        written_q.push_back(a);
        data_access(1'b0, a, '0, 4'hF, rd);
      end
    end

    for (int n = 0; n < N_FETCH; n++) begin
      a = written_q[$unsigned($random(seed)) % written_q.size()];
      instr_read(a, rd);
    end

    // tie from idle goes to the data port.
    set_wait(4'd2);
    for (int n = 0; n < N_PAIR; n++) begin
      a  = written_q[$unsigned($random(seed)) % written_q.size()];
      a2 = written_q[$unsigned($random(seed)) % written_q.size()];
      wd = $random(seed);
      fork
        data_access(n[0], a, wd, 4'hF, rd);
        instr_read(a2, rd_i);
      join
      if (d_seq > i_seq) note_failure("instruction port completed before data port on a tie");
    end

    set_endian(1'b1);
    for (int n = 0; n < N_LE; n++) begin
      le_addr[n] = 32'h0000_0400 + addr_t'(4 * n);
      le_data[n] = $random(seed);
      data_access(1'b1, le_addr[n], le_data[n], 4'hF, rd);
      data_access(1'b0, le_addr[n], '0, 4'hF, rd);
      check_word("o_dbus_rsp.rdata little-endian", rd, le_data[n]);
    end
    set_endian(1'b0);
    for (int n = 0; n < N_LE; n++) begin
      data_access(1'b0, le_addr[n], '0, 4'hF, rd);
      wd = {<<8{le_data[n]}};
      check_word("o_dbus_rsp.rdata big-endian", rd, wd);
    end

    // fetch withdrawn in its issue cycle.
    @(posedge CLK);
    ibus_req <= '{ren: 1'b1, wen: 1'b0, addr: written_q[0], wdata: '0, byte_en: 4'hF};
    @(posedge CLK);
    ibus_req <= '0;
    repeat (2 * MAX_WAIT) @(posedge CLK);   // window for a stray fetch completion.
    data_access(1'b0, written_q[0], '0, 4'hF, rd);   // arbiter back in idle.
    axil_read(REG_ICOUNT, rd);
    check_count("o_axil.rdata ICOUNT", rd, count_t'(i_done_cnt));
    axil_read(REG_DCOUNT, rd);
    check_count("o_axil.rdata DCOUNT", rd, count_t'(d_done_cnt));

    $display("errors: %0d value, %0d other", err_value, err_other);
    if (err_value + err_other == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule
